//--- verilog/frame_pkg.sv
// Shared types for the board-service block
// Sound sample and joystick word vectors, joystick bit positions,
// reset sequencer state encoding

`default_nettype none

package frame_pkg;

    typedef logic [15:0] snd_t;     // Game sound sample
    typedef logic [9:0]  joy_t;     // Joystick word, active high on the board side

    // Joystick word layout
    // Bits 3..0 are right, left, down, up
    localparam int JOY_BTN1  = 4;
    localparam int JOY_BTN3  = 6;
    localparam int JOY_COIN  = 7;
    localparam int JOY_START = 8;
    localparam int JOY_PAUSE = 9;

    // Reset sequencer states
    typedef enum logic [1:0] {
        ST_HOLD = 2'd0,     // Game held, hold period running or pending
        ST_LOAD = 2'd1,     // ROM download in progress
        ST_RUN  = 2'd2      // Game released
    } rst_state_e;

endpackage

`default_nettype wire

//--- verilog/rst_seq_fsm.sv
// Reset sequencer FSM
// Collects the reset causes and decides when the game leaves reset

`timescale 1ns/1ns
`default_nettype none

module rst_seq_fsm import frame_pkg::*; (
    input  logic clk_rgb,
    input  logic rst,
    input  logic dip_flip,
    input  logic rst_req,
    input  logic downloading,
    input  logic hold_done,
    output logic hold_start,
    output logic game_rst
);

    rst_state_e state;
    logic       dip_q;      // Last seen flip switch
    logic       armed;      // Hold count must be (re)started
    logic       trig;

    // Any change of the flip switch forces a new reset
    always_ff @(posedge clk_rgb) begin
        dip_q <= dip_flip;
    end

    assign trig = rst_req | (dip_flip != dip_q) | downloading;

    // Start the hold count on the first cycle free of triggers
    assign hold_start = armed & ~trig & (state != ST_RUN);

    assign game_rst = (state != ST_RUN);

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            state <= ST_HOLD;
            armed <= 1'b1;
        end else if (downloading) begin
            state <= ST_LOAD;
            armed <= 1'b1;
        end else if (trig) begin
            state <= ST_HOLD;   // Restarts an ongoing hold too
            armed <= 1'b1;
        end else begin
            case (state)
                ST_LOAD: begin
                    state <= ST_HOLD;   // Download over, hold_start fires now
                    armed <= 1'b0;
                end
                ST_HOLD: begin
                    if (armed) begin
                        armed <= 1'b0;
                    end else if (hold_done) begin
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    armed <= 1'b0;
                end
                default: begin
                    state <= ST_HOLD;
                    armed <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/hold_timer.sv
// Reset hold timer
// Down-counter loaded on hold_start, one done pulse per finished count

`timescale 1ns/1ns
`default_nettype none

module hold_timer #(
    parameter int RST_CYCLES = 16
) (
    input  logic clk_rgb,
    input  logic rst,
    input  logic hold_start,
    output logic hold_done
);

    localparam int CNT_W = $clog2(RST_CYCLES + 1);

    logic [CNT_W-1:0] cnt;     // Idle at zero

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            cnt       <= '0;
            hold_done <= 1'b0;
        end else if (hold_start) begin
            cnt       <= CNT_W'(RST_CYCLES);
            hold_done <= 1'b0;
        end else if (cnt != '0) begin
            cnt       <= cnt - 1'b1;
            hold_done <= (cnt == CNT_W'(1));  // High as the count lands on zero
        end else begin
            hold_done <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/snd_pwm_dac.sv
// First-order sigma-delta sound DAC
// 16-bit sample in, one-bit pulse-density stream out

`timescale 1ns/1ns
`default_nettype none

module snd_pwm_dac import frame_pkg::*; #(
    parameter bit SIGNED_SND = 1'b0
) (
    input  logic clk_rgb,
    input  logic rst,
    input  snd_t snd,
    output logic snd_pwm
);

    snd_t        snd_off;   // Sample as unsigned offset value
    snd_t        acc;
    logic [16:0] sum;

    // Two's complement to offset binary
    always_comb begin
        snd_off = snd;
        if (SIGNED_SND) begin
            snd_off[15] = ~snd[15];
        end
    end

    assign sum = {1'b0, acc} + {1'b0, snd_off};

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            acc     <= '0;
            snd_pwm <= 1'b0;
        end else begin
            acc     <= sum[15:0];
            snd_pwm <= sum[16];     // Carry gives the density
        end
    end

endmodule

`default_nettype wire

//--- verilog/joy_mapper.sv
// Joystick mapper
// Board joysticks to active-low game controls, coin and start split,
// pause toggle

`timescale 1ns/1ns
`default_nettype none

module joy_mapper import frame_pkg::*; #(
    parameter bit THREE_BUTTONS = 1'b0
) (
    input  logic       clk_rgb,
    input  logic       rst,
    input  logic       game_rst,
    input  joy_t       board_joystick1,
    input  joy_t       board_joystick2,
    output joy_t       game_joystick1,
    output joy_t       game_joystick2,
    output logic [1:0] game_coin,
    output logic [1:0] game_start,
    output logic       game_pause
);

    logic pause_in;
    logic pause_q;

    // Invert and mask the bits the game does not read
    function automatic joy_t map_joy(input joy_t board);
        joy_t game;
        game            = ~board;
        game[JOY_COIN]  = 1'b1;
        game[JOY_START] = 1'b1;
        game[JOY_PAUSE] = 1'b1;
        if (!THREE_BUTTONS) begin
            game[JOY_BTN3] = 1'b1;
        end
        return game;
    endfunction

    assign pause_in = board_joystick1[JOY_PAUSE] | board_joystick2[JOY_PAUSE];

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            game_joystick1 <= '1;   // All released
            game_joystick2 <= '1;
            game_coin      <= 2'b11;
            game_start     <= 2'b11;
        end else begin
            game_joystick1 <= map_joy(board_joystick1);
            game_joystick2 <= map_joy(board_joystick2);
            game_coin      <= ~{board_joystick2[JOY_COIN], board_joystick1[JOY_COIN]};
            game_start     <= ~{board_joystick2[JOY_START], board_joystick1[JOY_START]};
        end
    end

    // Pause flips on each press, game reset clears it
    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            pause_q    <= 1'b0;
            game_pause <= 1'b0;
        end else begin
            pause_q <= pause_in;
            if (game_rst) begin
                game_pause <= 1'b0;
            end else if (pause_in && !pause_q) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/frame_board.sv
// Board-service top level
// Reset sequencer with hold timer, sound DAC and joystick mapper

`timescale 1ns/1ns
`default_nettype none

module frame_board import frame_pkg::*; #(
    parameter int RST_CYCLES    = 16,
    parameter bit SIGNED_SND    = 1'b0,
    parameter bit THREE_BUTTONS = 1'b0
) (
    input  logic       clk_rgb,
    input  logic       rst,
    // Reset causes
    input  logic       dip_flip,
    input  logic       rst_req,
    input  logic       downloading,
    // Sound
    input  snd_t       snd,
    output logic       snd_pwm,
    output logic       game_rst,
    // Joysticks
    input  joy_t       board_joystick1,
    input  joy_t       board_joystick2,
    output joy_t       game_joystick1,
    output joy_t       game_joystick2,
    output logic [1:0] game_coin,
    output logic [1:0] game_start,
    output logic       game_pause
);

    logic hold_start;
    logic hold_done;

    rst_seq_fsm u_rst_seq (
        .clk_rgb        ( clk_rgb         ),
        .rst            ( rst             ),
        .dip_flip       ( dip_flip        ),
        .rst_req        ( rst_req         ),
        .downloading    ( downloading     ),
        .hold_done      ( hold_done       ),
        .hold_start     ( hold_start      ),
        .game_rst       ( game_rst        )
    );

    hold_timer #(.RST_CYCLES(RST_CYCLES)) u_hold (
        .clk_rgb        ( clk_rgb         ),
        .rst            ( rst             ),
        .hold_start     ( hold_start      ),
        .hold_done      ( hold_done       )
    );

    snd_pwm_dac #(.SIGNED_SND(SIGNED_SND)) u_dac (
        .clk_rgb        ( clk_rgb         ),
        .rst            ( rst             ),
        .snd            ( snd             ),
        .snd_pwm        ( snd_pwm         )
    );

    joy_mapper #(.THREE_BUTTONS(THREE_BUTTONS)) u_joy (
        .clk_rgb        ( clk_rgb         ),
        .rst            ( rst             ),
        .game_rst       ( game_rst        ),
        .board_joystick1( board_joystick1 ),
        .board_joystick2( board_joystick2 ),
        .game_joystick1 ( game_joystick1  ),
        .game_joystick2 ( game_joystick2  ),
        .game_coin      ( game_coin       ),
        .game_start     ( game_start      ),
        .game_pause     ( game_pause      )
    );

endmodule

`default_nettype wire

//--- dv/tb_frame_board.sv
// Testbench for the board-service top level
// Reference model of reset release, sound DAC, joystick mapping and pause,
// compared against the DUT on every cycle

`timescale 1ns/1ns
`default_nettype none

module tb_frame_board import frame_pkg::*;;

    localparam int RST_CYCLES    = 16;
    localparam bit SIGNED_SND    = 1'b1;
    localparam bit THREE_BUTTONS = 1'b0;
    localparam int SND_CYCLES    = 1000;
    localparam int JOY_CYCLES    = 300;
    // Reset and pause tests together stay well below 400 cycles
    localparam int MAX_CYCLES    = 2 * (SND_CYCLES + JOY_CYCLES) + 400;

    logic       clk_rgb;
    logic       rst;
    logic       dip_flip;
    logic       rst_req;
    logic       downloading;
    snd_t       snd;
    logic       snd_pwm;
    logic       game_rst;
    joy_t       board_joystick1;
    joy_t       board_joystick2;
    joy_t       game_joystick1;
    joy_t       game_joystick2;
    logic [1:0] game_coin;
    logic [1:0] game_start;
    logic       game_pause;

    // Reference model state, one step per rising edge
    string       test_name = "init";
    logic        model_valid = 1'b0;
    int          quiet;                 // Trigger-free edges so far
    logic        dip_ref_q = 1'b0;
    logic        trig_ref;
    logic        pause_in_ref;
    logic        pause_ref_q;
    snd_t        acc_ref;
    logic [16:0] sum_ref;
    logic        exp_rst, exp_pwm, exp_pause;
    joy_t        exp_joy1, exp_joy2;
    logic [1:0]  exp_coin, exp_start;
    int          cycle_cnt = 0;
    int          dl_len;

    frame_board #(
        .RST_CYCLES   ( RST_CYCLES    ),
        .SIGNED_SND   ( SIGNED_SND    ),
        .THREE_BUTTONS( THREE_BUTTONS )
    ) i_dut (
        .clk_rgb        ( clk_rgb         ),
        .rst            ( rst             ),
        .dip_flip       ( dip_flip        ),
        .rst_req        ( rst_req         ),
        .downloading    ( downloading     ),
        .snd            ( snd             ),
        .snd_pwm        ( snd_pwm         ),
        .game_rst       ( game_rst        ),
        .board_joystick1( board_joystick1 ),
        .board_joystick2( board_joystick2 ),
        .game_joystick1 ( game_joystick1  ),
        .game_joystick2 ( game_joystick2  ),
        .game_coin      ( game_coin       ),
        .game_start     ( game_start      ),
        .game_pause     ( game_pause      )
    );

    always #2 clk_rgb = ~clk_rgb;

    // Accumulator step, carry in bit 16
    function automatic logic [16:0] snd_step(input snd_t acc, input snd_t s);
        snd_t off;
        off = s;
        if (SIGNED_SND) begin
            off = s ^ 16'h8000;     // Signed sample to offset binary
        end
        return {1'b0, acc} + {1'b0, off};
    endfunction

    function automatic joy_t map_joy_ref(input joy_t b);
        joy_t m;
        m = ~b | 10'h380;           // Coin, start, pause read as released
        if (!THREE_BUTTONS) begin
            m = m | 10'h040;
        end
        return m;
    endfunction

    // Game stays in reset up to hold length plus one trigger-free edges
    function automatic logic rst_held(input int n);
        return (n <= RST_CYCLES + 1);
    endfunction

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bit(input string sig, input logic exp, input logic act);
        if (act !== exp) begin
            report_fail($sformatf("error: %s %s expected %b actual %b",
                                  test_name, sig, exp, act));
        end
    endtask

    task automatic check_snd(input string sig, input logic exp, input logic act);
        if (act !== exp) begin
            report_fail($sformatf("error: %s %s expected %b actual %b",
                                  test_name, sig, exp, act));
        end
    endtask

    task automatic check_joy(input string sig, input joy_t exp, input joy_t act);
        if (act !== exp) begin
            report_fail($sformatf("error: %s %s expected %h actual %h",
                                  test_name, sig, exp, act));
        end
    endtask

    // Outputs are compared at the falling edge, then the model takes the
    // inputs the DUT will sample at the next rising edge
    always @(negedge clk_rgb) begin
        if (model_valid) begin
            check_bit("game_rst", exp_rst, game_rst);
            check_snd("snd_pwm", exp_pwm, snd_pwm);
            check_joy("game_joystick1", exp_joy1, game_joystick1);
            check_joy("game_joystick2", exp_joy2, game_joystick2);
            check_bit("game_coin[0]", exp_coin[0], game_coin[0]);
            check_bit("game_coin[1]", exp_coin[1], game_coin[1]);
            check_bit("game_start[0]", exp_start[0], game_start[0]);
            check_bit("game_start[1]", exp_start[1], game_start[1]);
            check_bit("game_pause", exp_pause, game_pause);
            if (!THREE_BUTTONS) begin
                check_bit("button 3 of player 1", 1'b1, game_joystick1[JOY_BTN3]);
                check_bit("button 3 of player 2", 1'b1, game_joystick2[JOY_BTN3]);
            end
        end
        trig_ref  = rst_req | (dip_flip != dip_ref_q) | downloading;
        dip_ref_q = dip_flip;
        if (rst) begin
            quiet       = 0;
            acc_ref     = '0;
            exp_pwm     = 1'b0;
            exp_joy1    = '1;
            exp_joy2    = '1;
            exp_coin    = 2'b11;
            exp_start   = 2'b11;
            pause_ref_q = 1'b0;
            exp_pause   = 1'b0;
            exp_rst     = 1'b1;
        end else begin
            if (trig_ref) begin
                quiet = 0;
            end else if (quiet < RST_CYCLES + 2) begin
                quiet = quiet + 1;
            end
            sum_ref   = snd_step(acc_ref, snd);
            acc_ref   = sum_ref[15:0];
            exp_pwm   = sum_ref[16];
            exp_joy1  = map_joy_ref(board_joystick1);
            exp_joy2  = map_joy_ref(board_joystick2);
            exp_coin  = ~{board_joystick2[JOY_COIN], board_joystick1[JOY_COIN]};
            exp_start = ~{board_joystick2[JOY_START], board_joystick1[JOY_START]};
            pause_in_ref = board_joystick1[JOY_PAUSE] | board_joystick2[JOY_PAUSE];
            if (exp_rst) begin
                exp_pause = 1'b0;   // Uses game_rst from before this edge
            end else if (pause_in_ref && !pause_ref_q) begin
                exp_pause = ~exp_pause;
            end
            pause_ref_q = pause_in_ref;
            exp_rst     = rst_held(quiet);
        end
        model_valid = 1'b1;
    end

    always @(posedge clk_rgb) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            report_fail("timeout: the tests did not finish in time");
        end
    end

    // Returns at the falling edge once game_rst is low
    task automatic wait_release();
        @(negedge clk_rgb);
        while (game_rst !== 1'b0) begin
            @(negedge clk_rgb);
        end
    endtask

    task automatic pulse_rst_req();
        @(posedge clk_rgb);
        rst_req <= 1'b1;
        @(posedge clk_rgb);
        rst_req <= 1'b0;
    endtask

    task automatic toggle_flip();
        @(posedge clk_rgb);
        dip_flip <= ~dip_flip;
        @(posedge clk_rgb);
    endtask

    // Held for several cycles, so only the rising edge may toggle
    task automatic press_pause(input int player);
        @(posedge clk_rgb);
        if (player == 1) begin
            board_joystick1[JOY_PAUSE] <= 1'b1;
        end else begin
            board_joystick2[JOY_PAUSE] <= 1'b1;
        end
        repeat (3) @(posedge clk_rgb);
        board_joystick1[JOY_PAUSE] <= 1'b0;
        board_joystick2[JOY_PAUSE] <= 1'b0;
        repeat (2) @(posedge clk_rgb);
        @(negedge clk_rgb);
    endtask

    initial begin
        void'($urandom(32'h3e90));
        clk_rgb         = 1'b0;
        rst             = 1'b1;
        dip_flip        = 1'b0;
        rst_req         = 1'b0;
        downloading     = 1'b0;
        snd             = '0;
        board_joystick1 = '0;
        board_joystick2 = '0;

        test_name = "reset";
        repeat (10) @(posedge clk_rgb);
        rst <= 1'b0;
        wait_release();

        test_name = "rst_req";
        pulse_rst_req();
        wait_release();

        test_name = "dip_flip";
        toggle_flip();
        wait_release();

        test_name = "download";
        dl_len = 4 + int'($urandom % 32'd40);
        @(posedge clk_rgb);
        downloading <= 1'b1;
        repeat (dl_len) @(posedge clk_rgb);
        downloading <= 1'b0;
        repeat (8) @(posedge clk_rgb);      // Inside the hold period
        pulse_rst_req();
        wait_release();

        test_name = "sound";
        repeat (SND_CYCLES) begin
            @(posedge clk_rgb);
            snd <= snd_t'($urandom);
        end
        @(posedge clk_rgb);
        snd <= '0;

        test_name = "joystick";
        repeat (JOY_CYCLES) begin
            @(posedge clk_rgb);
            board_joystick1 <= joy_t'($urandom);
            board_joystick2 <= joy_t'($urandom);
        end
        @(posedge clk_rgb);
        board_joystick1 <= '0;
        board_joystick2 <= '0;

        test_name = "pause";
        pulse_rst_req();
        wait_release();
        check_bit("game_pause", 1'b0, game_pause);
        press_pause(1);
        check_bit("game_pause", 1'b1, game_pause);
        press_pause(2);
        check_bit("game_pause", 1'b0, game_pause);
        press_pause(1);
        check_bit("game_pause", 1'b1, game_pause);
        pulse_rst_req();
        @(negedge clk_rgb);
        @(negedge clk_rgb);
        check_bit("game_rst", 1'b1, game_rst);
        check_bit("game_pause", 1'b0, game_pause);
        wait_release();

        repeat (4) @(posedge clk_rgb);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/frame_pkg.sv
verilog/rst_seq_fsm.sv
verilog/hold_timer.sv
verilog/snd_pwm_dac.sv
verilog/joy_mapper.sv
verilog/frame_board.sv
dv/tb_frame_board.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the board-service testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
    -f project.f \
    --top-module tb_frame_board \
    -o sim_tb

# The simulator exits non-zero on a failed check, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
